/* hw/ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// datapath width of the integer cluster
`define OOO_XLEN 32

// destination tag width, 16 tags can be in flight
`define OOO_TAG_W 4

// reservation station depth
`define OOO_RS_DEPTH 8

// index width into the station, log2 of the depth
`define OOO_RS_IDX_W 3

`endif

/* hw/ooo_pkg.sv */
`include "ooo_defines.svh"

package ooo_pkg;

    // alu opcodes, encodings 6 and 7 are unused
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_orr = 3'd3,
        op_eor = 3'd4,
        op_lsl = 3'd5
    } alu_op_t;

    // one source operand, either a value or a tag still waiting
    typedef struct packed {
        logic                  ready;
        logic [`OOO_TAG_W-1:0] tag;
        logic [`OOO_XLEN-1:0]  value;
    } operand_t;

    // condition flags in arm order
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

    // one reservation station slot
    typedef struct packed {
        logic                  busy;
        alu_op_t               op;
        operand_t              src1;
        operand_t              src2;
        logic [`OOO_TAG_W-1:0] dst_tag;
        logic                  set_nzcv;
    } rs_entry_t;

endpackage

/* hw/lowest_set_pick.sv */
`timescale 1ns/1ps

module lowest_set_pick #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]                           req,
    output logic                                       found,
    output logic [((WIDTH > 1) ? $clog2(WIDTH) : 1)-1:0] index
);

    // index width, at least one bit so a single request still works
    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    // walk from the top bit down so the lowest set bit is the last one written
    always_comb begin
        found = 1'b0;
        index = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                found = 1'b1;
                index = IDX_W'(i);
            end
        end
    end

    // found is only a summary of the request vector
    // index holds zero when nothing is requested

endmodule

/* hw/result_bus_if.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

interface result_bus_if;

    // broadcast strobe, one result per cycle
    logic                  valid;
    logic [`OOO_TAG_W-1:0] tag;
    logic [`OOO_XLEN-1:0]  value;
    // flags only mean something when nzcv_valid is set
    ooo_pkg::nzcv_t        nzcv;
    logic                  nzcv_valid;

    // the unit that owns the bus
    modport producer (
        output valid, tag, value, nzcv, nzcv_valid
    );

    // every listener samples whenever valid is high, there is no acknowledge
    modport listener (
        input valid, tag, value, nzcv, nzcv_valid
    );

endinterface

/* hw/issue_if.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

interface issue_if;

    // one instruction handed over per cycle with valid high
    logic                  valid;
    ooo_pkg::alu_op_t      op;
    // both operands already resolved to values
    logic [`OOO_XLEN-1:0]  a;
    logic [`OOO_XLEN-1:0]  b;
    logic [`OOO_TAG_W-1:0] dst_tag;
    logic                  set_nzcv;

    // reservation station side
    modport station (
        output valid, op, a, b, dst_tag, set_nzcv
    );

    // execution unit side
    // the unit never stalls, so there is no ready back
    modport unit (
        input valid, op, a, b, dst_tag, set_nzcv
    );

endinterface

/* hw/reservation_station.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reservation_station (
    input  logic                  in_clk,
    input  logic                  in_reset,
    input  logic                  flush,
    input  logic                  dispatch_valid,
    input  ooo_pkg::rs_entry_t    dispatch_entry,
    output logic                  rs_full,
    result_bus_if.listener        alu_bus,
    result_bus_if.listener        ext_bus,
    issue_if.station              issue
);

    localparam int DEPTH = `OOO_RS_DEPTH;

    // slot storage, only the busy bits are control state
    ooo_pkg::rs_entry_t [DEPTH-1:0] entries;

    // selection masks and picker results
    logic [DEPTH-1:0]          free_mask;
    logic [DEPTH-1:0]          ready_mask;
    logic                      free_found;
    logic                      ready_found;
    logic [`OOO_RS_IDX_W-1:0]  free_idx;
    logic [`OOO_RS_IDX_W-1:0]  ready_idx;

    // dispatch entry after snooping the buses in the same cycle
    ooo_pkg::rs_entry_t        new_entry;

    // set when two busy slots wait to produce the same tag
    logic                      dst_clash;

    // capture a broadcast value for a waiting operand
    // operands that are already ready keep their value
    function automatic ooo_pkg::operand_t snoop(input ooo_pkg::operand_t opnd);
        ooo_pkg::operand_t res;
        res = opnd;
        if (!opnd.ready) begin
            if (alu_bus.valid && (alu_bus.tag == opnd.tag)) begin
                res.ready = 1'b1;
                res.value = alu_bus.value;
            end else if (ext_bus.valid && (ext_bus.tag == opnd.tag)) begin
                res.ready = 1'b1;
                res.value = ext_bus.value;
            end
        end
        return res;
    endfunction

    // a slot is free when not busy, ready when both sources are in
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            free_mask[i]  = !entries[i].busy;
            ready_mask[i] = entries[i].busy && entries[i].src1.ready && entries[i].src2.ready;
        end
    end

    // lowest free slot takes the next dispatch
    lowest_set_pick #(
        .WIDTH (DEPTH)
    ) u_free_pick (
        .req   (free_mask),
        .found (free_found),
        .index (free_idx)
    );

    // lowest ready slot issues first
    lowest_set_pick #(
        .WIDTH (DEPTH)
    ) u_ready_pick (
        .req   (ready_mask),
        .found (ready_found),
        .index (ready_idx)
    );

    assign rs_full = !free_found;

    // dispatch bypass, a source matching a live broadcast is captured now
    always_comb begin
        new_entry      = dispatch_entry;
        new_entry.busy = 1'b1;
        new_entry.src1 = snoop(dispatch_entry.src1);
        new_entry.src2 = snoop(dispatch_entry.src2);
    end

    // issue straight from storage, the alu takes it at the next edge
    assign issue.valid    = ready_found;
    assign issue.op       = entries[ready_idx].op;
    assign issue.a        = entries[ready_idx].src1.value;
    assign issue.b        = entries[ready_idx].src2.value;
    assign issue.dst_tag  = entries[ready_idx].dst_tag;
    assign issue.set_nzcv = entries[ready_idx].set_nzcv;

    always_ff @(posedge in_clk) begin
        if (in_reset || flush) begin
            // mispredict drops every slot at once
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else begin
            // wakeup of waiting operands in busy slots
            for (int i = 0; i < DEPTH; i++) begin
                if (entries[i].busy) begin
                    entries[i].src1 <= snoop(entries[i].src1);
                    entries[i].src2 <= snoop(entries[i].src2);
                end
            end
            // slot leaves together with the handover
            if (ready_found) begin
                entries[ready_idx].busy <= 1'b0;
            end
            // free slot is never the issuing one, so no overlap here
            if (dispatch_valid && free_found) begin
                entries[free_idx] <= new_entry;
            end
        end
    end

    // pairwise compare of destination tags over busy slots
    always_comb begin
        dst_clash = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            for (int j = i + 1; j < DEPTH; j++) begin
                if (entries[i].busy && entries[j].busy &&
                    (entries[i].dst_tag == entries[j].dst_tag)) begin
                    dst_clash = 1'b1;
                end
            end
        end
    end

    // dispatch must respect the full flag of the previous cycle
    a_no_dispatch_when_full : assert property (
        @(posedge in_clk) disable iff (in_reset)
        dispatch_valid |-> !rs_full
    ) else $error("dispatch while reservation station full");

    // tags are unique among in-flight producers
    a_unique_dst_tag : assert property (
        @(posedge in_clk) disable iff (in_reset)
        !dst_clash
    ) else $error("two busy entries share a destination tag");

    // alu and external producers never finish the same tag together
    a_bus_tag_conflict : assert property (
        @(posedge in_clk) disable iff (in_reset)
        (alu_bus.valid && ext_bus.valid) |-> (alu_bus.tag != ext_bus.tag)
    ) else $error("alu and external bus broadcast the same tag");

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module alu_unit (
    input  logic             in_clk,
    input  logic             in_reset,
    input  logic             flush,
    issue_if.unit            issue,
    result_bus_if.producer   result
);

    // stage one, operands straight from issue
    logic                  s1_valid;
    ooo_pkg::alu_op_t      s1_op;
    logic [`OOO_XLEN-1:0]  s1_a;
    logic [`OOO_XLEN-1:0]  s1_b;
    logic [`OOO_TAG_W-1:0] s1_dst_tag;
    logic                  s1_set_nzcv;

    // stage two, finished result
    logic                  s2_valid;
    logic [`OOO_XLEN-1:0]  s2_value;
    logic [`OOO_TAG_W-1:0] s2_tag;
    ooo_pkg::nzcv_t        s2_nzcv;
    logic                  s2_nzcv_valid;

    // combinational execute between the stages
    logic [`OOO_XLEN:0]    add_full;
    logic [`OOO_XLEN:0]    sub_full;
    logic [`OOO_XLEN-1:0]  exe_value;
    ooo_pkg::nzcv_t        exe_nzcv;

    // carry out lands in the top bit
    assign add_full = {1'b0, s1_a} + {1'b0, s1_b};
    // subtract as a + ~b + 1, so c is set when there is no borrow
    assign sub_full = {1'b0, s1_a} + {1'b0, ~s1_b} + {{`OOO_XLEN{1'b0}}, 1'b1};

    always_comb begin
        exe_nzcv.c = 1'b0;
        exe_nzcv.v = 1'b0;
        case (s1_op)
            ooo_pkg::op_add: begin
                exe_value  = add_full[`OOO_XLEN-1:0];
                exe_nzcv.c = add_full[`OOO_XLEN];
                // same-sign inputs with a sign flip overflow
                exe_nzcv.v = (s1_a[`OOO_XLEN-1] == s1_b[`OOO_XLEN-1]) &&
                             (exe_value[`OOO_XLEN-1] != s1_a[`OOO_XLEN-1]);
            end
            ooo_pkg::op_sub: begin
                exe_value  = sub_full[`OOO_XLEN-1:0];
                exe_nzcv.c = sub_full[`OOO_XLEN];
                exe_nzcv.v = (s1_a[`OOO_XLEN-1] != s1_b[`OOO_XLEN-1]) &&
                             (exe_value[`OOO_XLEN-1] != s1_a[`OOO_XLEN-1]);
            end
            ooo_pkg::op_and: exe_value = s1_a & s1_b;
            ooo_pkg::op_orr: exe_value = s1_a | s1_b;
            ooo_pkg::op_eor: exe_value = s1_a ^ s1_b;
            // shift amount from the low five bits only
            ooo_pkg::op_lsl: exe_value = s1_a << s1_b[4:0];
            default:         exe_value = '0;
        endcase
        exe_nzcv.n = exe_value[`OOO_XLEN-1];
        exe_nzcv.z = (exe_value == '0);
    end

    // valid bits cleared on reset and mispredict
    always_ff @(posedge in_clk) begin
        if (in_reset || flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid;
        end
    end

    // payload pipeline
    always_ff @(posedge in_clk) begin
        s1_op         <= issue.op;
        s1_a          <= issue.a;
        s1_b          <= issue.b;
        s1_dst_tag    <= issue.dst_tag;
        s1_set_nzcv   <= issue.set_nzcv;
        s2_value      <= exe_value;
        s2_tag        <= s1_dst_tag;
        s2_nzcv       <= exe_nzcv;
        s2_nzcv_valid <= s1_set_nzcv;
    end

    // broadcast straight from stage two registers
    assign result.valid      = s2_valid;
    assign result.tag        = s2_tag;
    assign result.value      = s2_value;
    assign result.nzcv       = s2_nzcv;
    assign result.nzcv_valid = s2_valid && s2_nzcv_valid;

    // a station entry never carries an unused opcode
    a_legal_opcode : assert property (
        @(posedge in_clk) disable iff (in_reset)
        s1_valid |-> (s1_op inside {ooo_pkg::op_add, ooo_pkg::op_sub, ooo_pkg::op_and,
                                    ooo_pkg::op_orr, ooo_pkg::op_eor, ooo_pkg::op_lsl})
    ) else $error("illegal alu opcode in execute stage");

endmodule

/* hw/issue_cluster_top.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module issue_cluster_top (
    input  logic                  in_clk,
    input  logic                  in_reset,
    input  logic                  flush,
    // dispatch of one renamed instruction
    input  logic                  dispatch_valid,
    input  ooo_pkg::alu_op_t      dispatch_op,
    input  logic                  src1_ready,
    input  logic [`OOO_TAG_W-1:0] src1_tag,
    input  logic [`OOO_XLEN-1:0]  src1_value,
    input  logic                  src2_ready,
    input  logic [`OOO_TAG_W-1:0] src2_tag,
    input  logic [`OOO_XLEN-1:0]  src2_value,
    input  logic [`OOO_TAG_W-1:0] dst_tag,
    input  logic                  set_nzcv,
    // results from loads and other units
    input  logic                  ext_valid,
    input  logic [`OOO_TAG_W-1:0] ext_tag,
    input  logic [`OOO_XLEN-1:0]  ext_value,
    output logic                  rs_full,
    // alu broadcast seen from outside
    output logic                  result_valid,
    output logic [`OOO_TAG_W-1:0] result_tag,
    output logic [`OOO_XLEN-1:0]  result_value,
    output logic [3:0]            result_nzcv,
    output logic                  result_nzcv_valid
);

    result_bus_if alu_bus ();
    result_bus_if ext_bus ();
    issue_if      issue ();

    ooo_pkg::rs_entry_t dispatch_entry;

    // pack dispatch ports into one entry, the station sets busy itself
    assign dispatch_entry.busy     = 1'b1;
    assign dispatch_entry.op       = dispatch_op;
    assign dispatch_entry.src1     = '{ready: src1_ready, tag: src1_tag, value: src1_value};
    assign dispatch_entry.src2     = '{ready: src2_ready, tag: src2_tag, value: src2_value};
    assign dispatch_entry.dst_tag  = dst_tag;
    assign dispatch_entry.set_nzcv = set_nzcv;

    // external producers carry no flags
    assign ext_bus.valid      = ext_valid;
    assign ext_bus.tag        = ext_tag;
    assign ext_bus.value      = ext_value;
    assign ext_bus.nzcv       = '0;
    assign ext_bus.nzcv_valid = 1'b0;

    reservation_station u_rs (
        .in_clk         (in_clk),
        .in_reset       (in_reset),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .rs_full        (rs_full),
        .alu_bus        (alu_bus.listener),
        .ext_bus        (ext_bus.listener),
        .issue          (issue.station)
    );

    alu_unit u_alu (
        .in_clk   (in_clk),
        .in_reset (in_reset),
        .flush    (flush),
        .issue    (issue.unit),
        .result   (alu_bus.producer)
    );

    // result ports mirror the alu bus
    assign result_valid      = alu_bus.valid;
    assign result_tag        = alu_bus.tag;
    assign result_value      = alu_bus.value;
    assign result_nzcv       = alu_bus.nzcv;
    assign result_nzcv_valid = alu_bus.nzcv_valid;

endmodule

/* bench/tb_issue_cluster.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module tb_issue_cluster;

    localparam int N_RANDOM = 16;
    localparam int N_TAGS   = 1 << `OOO_TAG_W;

    logic                  in_clk = 1'b0;
    logic                  in_reset;
    logic                  flush;
    logic                  dispatch_valid;
    ooo_pkg::alu_op_t      dispatch_op;
    logic                  src1_ready;
    logic [`OOO_TAG_W-1:0] src1_tag;
    logic [`OOO_XLEN-1:0]  src1_value;
    logic                  src2_ready;
    logic [`OOO_TAG_W-1:0] src2_tag;
    logic [`OOO_XLEN-1:0]  src2_value;
    logic [`OOO_TAG_W-1:0] dst_tag;
    logic                  set_nzcv;
    logic                  ext_valid;
    logic [`OOO_TAG_W-1:0] ext_tag;
    logic [`OOO_XLEN-1:0]  ext_value;
    logic                  rs_full;
    logic                  result_valid;
    logic [`OOO_TAG_W-1:0] result_tag;
    logic [`OOO_XLEN-1:0]  result_value;
    logic [3:0]            result_nzcv;
    logic                  result_nzcv_valid;

    // scoreboard slots indexed by destination tag
    logic [N_TAGS-1:0]     pending;
    logic [`OOO_XLEN-1:0]  exp_value [N_TAGS];
    logic [3:0]            exp_nzcv [N_TAGS];
    logic                  exp_set [N_TAGS];
    int                    exp_lat [N_TAGS];
    int                    disp_cycle [N_TAGS];
    string                 test_name [N_TAGS];
    int                    pending_count = 0;
    int                    cycle_cnt = 0;
    logic [31:0]           rng_state = 32'h7ffef667;
    // stimulus lines and their numbers in the file
    string                 lines [$];
    int                    line_nums [$];
    logic                  lines_loaded = 1'b0;

    issue_cluster_top dut (
        .in_clk (in_clk), .in_reset (in_reset), .flush (flush),
        .dispatch_valid (dispatch_valid), .dispatch_op (dispatch_op),
        .src1_ready (src1_ready), .src1_tag (src1_tag), .src1_value (src1_value),
        .src2_ready (src2_ready), .src2_tag (src2_tag), .src2_value (src2_value),
        .dst_tag (dst_tag), .set_nzcv (set_nzcv),
        .ext_valid (ext_valid), .ext_tag (ext_tag), .ext_value (ext_value),
        .rs_full (rs_full), .result_valid (result_valid), .result_tag (result_tag),
        .result_value (result_value), .result_nzcv (result_nzcv),
        .result_nzcv_valid (result_nzcv_valid)
    );

    always #10 in_clk = ~in_clk;

    // counts rising edges for the latency check
    always @(posedge in_clk) cycle_cnt <= cycle_cnt + 1;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("[ERROR] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reference model for add and eor returning {nzcv, value}
    function automatic logic [35:0] alu_model(input logic [2:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [32:0] sum;
        logic [31:0] val;
        logic        c;
        logic        v;
        if (op == 3'd0) begin
            sum = {1'b0, a} + {1'b0, b};
            val = sum[31:0];
            c   = sum[32];
            // both positive gives negative, or both negative gives positive
            v   = (a[31] & b[31] & ~val[31]) | (~a[31] & ~b[31] & val[31]);
        end else begin
            val = a ^ b;
            c   = 1'b0;
            v   = 1'b0;
        end
        return {val[31], (val == 32'd0), c, v, val};
    endfunction

    task automatic set_idle;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = ooo_pkg::op_add;
        src1_ready     = 1'b0;
        src1_tag       = '0;
        src1_value     = '0;
        src2_ready     = 1'b0;
        src2_tag       = '0;
        src2_value     = '0;
        dst_tag        = '0;
        set_nzcv       = 1'b0;
        ext_valid      = 1'b0;
        ext_tag        = '0;
        ext_value      = '0;
    endtask

    task automatic drive_dispatch(input logic [2:0] op, input logic r1, input logic [3:0] t1,
                                  input logic [31:0] v1, input logic r2, input logic [3:0] t2,
                                  input logic [31:0] v2, input logic [3:0] dst,
                                  input logic setf);
        if (rs_full) fail_run("dispatch attempted while the reservation station is full");
        dispatch_valid = 1'b1;
        dispatch_op    = ooo_pkg::alu_op_t'(op);
        src1_ready     = r1;
        src1_tag       = t1;
        src1_value     = v1;
        src2_ready     = r2;
        src2_tag       = t2;
        src2_value     = v2;
        dst_tag        = dst;
        set_nzcv       = setf;
    endtask

    task automatic expect_result(input logic [3:0] tag, input string name,
                                 input logic [31:0] value, input logic [3:0] nzcv,
                                 input logic setf, input int lat);
        if (pending[tag]) begin
            fail_run($sformatf("%s reuses tag %0d while it is still in flight", name, tag));
        end
        pending[tag]    = 1'b1;
        exp_value[tag]  = value;
        exp_nzcv[tag]   = nzcv;
        exp_set[tag]    = setf;
        exp_lat[tag]    = lat;
        test_name[tag]  = name;
        // the edge that takes this dispatch
        disp_cycle[tag] = cycle_cnt + 1;
        pending_count++;
    endtask

    // mid-cycle look at the result bus
    task automatic observe_result;
        logic [`OOO_TAG_W-1:0] tag;
        if (result_valid) begin
            tag = result_tag;
            if (!pending[tag]) begin
                fail_run($sformatf("broadcast of tag %0d that no live instruction owns", tag));
            end
            check_equal({test_name[tag], " value"}, exp_value[tag], result_value);
            check_equal({test_name[tag], " nzcv_valid"}, exp_set[tag], result_nzcv_valid);
            if (exp_set[tag]) check_equal({test_name[tag], " nzcv"}, exp_nzcv[tag], result_nzcv);
            if (exp_lat[tag] != 0) begin
                check_equal({test_name[tag], " latency"}, exp_lat[tag],
                            cycle_cnt - disp_cycle[tag]);
            end
            pending[tag] = 1'b0;
            pending_count--;
        end
    endtask

    task automatic next_cycle;
        @(negedge in_clk);
        observe_result();
        set_idle();
    endtask

    task automatic drain_results;
        while (pending_count > 0) next_cycle();
    endtask

    task automatic load_stimulus;
        int    fd;
        int    num;
        string text;
        fd = $fopen("bench/dispatch_input.txt", "r");
        if (fd == 0) fail_run("cannot open bench/dispatch_input.txt");
        num = 0;
        while ($fgets(text, fd) != 0) begin
            num++;
            // skip comments and blank lines
            if (text.len() > 0 && text[0] != "#" && text[0] != "\n") begin
                lines.push_back(text);
                line_nums.push_back(num);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_line(input string text, input int num);
        byte         kind;
        string       rest;
        string       name;
        int          n;
        int          lat;
        logic [31:0] op, r1, t1, v1, r2, t2, v2, dst, setf, expv, expn;
        kind = text[0];
        rest = text.substr(1, text.len() - 1);
        name = $sformatf("line %0d", num);
        case (kind)
            "D": begin
                n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %d",
                            op, r1, t1, v1, r2, t2, v2, dst, setf, expv, expn, lat);
                if (n != 12) fail_run($sformatf("malformed dispatch on %s", name));
                drive_dispatch(op[2:0], r1[0], t1[3:0], v1, r2[0], t2[3:0], v2, dst[3:0],
                               setf[0]);
                expect_result(dst[3:0], name, expv, expn[3:0], setf[0], lat);
            end
            "E": begin
                n = $sscanf(rest, "%h %h", t1, v1);
                if (n != 2) fail_run($sformatf("malformed external broadcast on %s", name));
                ext_valid = 1'b1;
                ext_tag   = t1[3:0];
                ext_value = v1;
            end
            "F": begin
                // flushed tags must never show up again
                flush         = 1'b1;
                pending_count = 0;
                pending       = '0;
            end
            "R": begin
                n = $sscanf(rest, "%h", r1);
                check_equal({name, " rs_full"}, r1, rs_full);
            end
            "I": ;
            "W": drain_results();
            default: fail_run($sformatf("unknown line kind on %s", name));
        endcase
    endtask

    // independent add or eor with ready operands
    task automatic random_dispatch(input int idx);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ctl;
        logic [35:0] model;
        logic [2:0]  op;
        logic [3:0]  tag;
        rng_state = xorshift32(rng_state);
        a         = rng_state;
        rng_state = xorshift32(rng_state);
        b         = rng_state;
        rng_state = xorshift32(rng_state);
        ctl       = rng_state;
        op        = ctl[0] ? 3'd4 : 3'd0;
        // tags 12 to 15 stay reserved for external producers
        tag = ctl[7:4] % 4'd12;
        while (pending[tag]) tag = (tag == 4'd11) ? 4'd0 : tag + 4'd1;
        model = alu_model(op, a, b);
        drive_dispatch(op, 1'b1, 4'd0, a, 1'b1, 4'd0, b, tag, ctl[1]);
        expect_result(tag, $sformatf("random %0d", idx), model[31:0], model[35:32], ctl[1], 0);
    endtask

    // bound from the length of the tests
    initial begin
        int limit;
        wait (lines_loaded);
        limit = (lines.size() + N_RANDOM) * 40 + 200;
        repeat (limit) @(posedge in_clk);
        fail_run("timeout, results stopped arriving before the tests finished");
    end

    initial begin
        pending  = '0;
        in_reset = 1'b1;
        set_idle();
        load_stimulus();
        lines_loaded = 1'b1;
        repeat (4) @(posedge in_clk);
        @(negedge in_clk);
        in_reset = 1'b0;
        for (int i = 0; i < lines.size(); i++) begin
            next_cycle();
            apply_line(lines[i], line_nums[i]);
        end
        drain_results();
        for (int i = 0; i < N_RANDOM; i++) begin
            next_cycle();
            random_dispatch(i);
        end
        drain_results();
        // a few quiet cycles to catch stray broadcasts
        repeat (3) next_cycle();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/ooo_pkg.sv
hw/lowest_set_pick.sv
hw/result_bus_if.sv
hw/issue_if.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/issue_cluster_top.sv
bench/tb_issue_cluster.sv

/* bench/dispatch_input.txt */
# D op s1_rdy s1_tag s1_val s2_rdy s2_tag s2_val dst set_nzcv exp_val exp_nzcv lat(dec, 0 = any)
# E tag value = external broadcast, F = flush, R full = rs_full check, I = idle, W = wait drain
# alone in an idle cluster
D 0 1 0 00000005 1 0 00000007 1 1 0000000c 0 2
W
# every opcode, add and sub carry and overflow
D 0 1 0 7fffffff 1 0 00000001 1 1 80000000 9 2
D 0 1 0 ffffffff 1 0 00000001 2 1 00000000 6 2
D 1 1 0 00000005 1 0 00000007 3 1 fffffffe 8 2
D 1 1 0 80000000 1 0 00000001 4 1 7fffffff 3 2
D 2 1 0 f0f0f0f0 1 0 ff00ff00 5 1 f000f000 8 2
D 3 1 0 0000000f 1 0 000000f0 6 0 000000ff 0 2
D 4 1 0 aaaaaaaa 1 0 aaaaaaaa 7 1 00000000 4 2
D 5 1 0 00000003 1 0 00000021 8 1 00000006 0 2
D 1 1 0 00000009 1 0 00000009 9 1 00000000 6 2
W
# chain through the alu bus, fourth line meets the tag 1 broadcast
D 0 1 0 00000010 1 0 00000020 1 0 00000030 0 2
D 0 0 1 00000000 1 0 00000005 2 0 00000035 0 0
I
D 1 0 1 00000000 1 0 00000010 3 1 00000020 2 0
D 4 0 2 00000000 0 3 00000000 4 0 00000015 0 0
W
# wakeup from the external bus, out of order
D 0 0 c 00000000 1 0 00000001 1 0 00000101 0 0
D 3 0 d 00000000 0 c 00000000 2 0 00001100 0 0
D 2 1 0 0000ffff 0 e 00000000 3 1 00005678 0 0
I
E e 12345678
E c 00000100
I
E d 00001000
W
# fill the station on an absent tag, then flush
D 0 0 f 00000000 1 0 00000001 1 0 00000002 0 0
D 0 0 f 00000000 1 0 00000002 2 0 00000003 0 0
D 0 0 f 00000000 1 0 00000003 3 0 00000004 0 0
D 0 0 f 00000000 1 0 00000004 4 0 00000005 0 0
D 0 0 f 00000000 1 0 00000005 5 0 00000006 0 0
D 0 0 f 00000000 1 0 00000006 6 0 00000007 0 0
D 0 0 f 00000000 1 0 00000007 7 0 00000008 0 0
D 0 0 f 00000000 1 0 00000008 8 0 00000009 0 0
R 1
F
R 0
E f 00000001
I
I
I
I
D 0 1 0 00000003 1 0 00000004 9 1 00000007 0 2
W
